// File: rtl/decodeCfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

// one instruction word
`define INSTR_WIDTH 32

// full 64-bit effective address
`define ADDR_WIDTH 64

// index into the 32 GPRs
`define REG_WIDTH 5

////////////////////////////////////////////////////////////
// buffering
////////////////////////////////////////////////////////////

// ring entries in the instruction queue
// the queue output register holds one more word on top of these
`define QUEUE_DEPTH 4

`endif

// File: rtl/decodePkg.sv
`default_nettype none

`include "decodeCfg.svh"

package decodePkg;

	////////////////////////////////////////////////////////////
	// vector types, bit 0 is the msb throughout
	////////////////////////////////////////////////////////////
	typedef logic [0:`INSTR_WIDTH-1] instrT;
	typedef logic [0:`ADDR_WIDTH-1] addrT;
	typedef logic [0:`REG_WIDTH-1] regIdxT;
	typedef logic [0:63] immT;
	typedef logic [0:5] opcodeT;
	typedef logic [0:9] xOpcodeT;

	typedef enum logic [2:0]
	{
		INVALID,
		D,
		DS,
		X,
		XO,
		MD
	} formatT;

	// primary opcodes
	localparam opcodeT OP_ADDI = 6'd14;
	localparam opcodeT OP_ADDIS = 6'd15;
	localparam opcodeT OP_ORI = 6'd24;
	localparam opcodeT OP_LD = 6'd58;
	localparam opcodeT OP_RLDICL = 6'd30;
	localparam opcodeT OP_X = 6'd31;

	// extended opcodes under 31 that belong to XO
	localparam xOpcodeT XOP_ADD = 10'd266;
	localparam xOpcodeT XOP_SUBF = 10'd40;

	////////////////////////////////////////////////////////////
	// pipeline payloads
	////////////////////////////////////////////////////////////
	typedef struct packed
	{
		instrT instr;
		addrT addr;
	} fetchedT;

	typedef struct packed
	{
		formatT format;
		opcodeT opcode;
		xOpcodeT xOpcode;
		logic xOpcodeEnable;
		regIdxT reg1;
		regIdxT reg2;
		regIdxT reg3;
		logic reg1Enable;
		logic reg2Enable;
		logic reg3Enable;
		logic reg3IsImmediate;
		logic reg2ValOrZero;
		immT imm;
		logic immEnable;
		addrT addr;
	} decodedT;

	// raw per-format fields between the two decode stages
	typedef struct packed
	{
		logic dMatch;
		regIdxT dReg1;
		regIdxT dReg2;
		logic [0:15] dImm;
		logic dSigned;
		logic dShift;
		logic dReg2ValOrZero;
		logic dsMatch;
		regIdxT dsReg1;
		regIdxT dsReg2;
		logic [0:13] dsImm;
		logic xMatch;
		regIdxT xReg1;
		regIdxT xReg2;
		regIdxT xReg3;
		xOpcodeT xXop;
		logic xoMatch;
		regIdxT xoReg1;
		regIdxT xoReg2;
		regIdxT xoReg3;
		logic [0:8] xoXop;
		logic mdMatch;
		regIdxT mdReg1;
		regIdxT mdReg2;
		logic [0:5] mdShift;
		opcodeT opcode;
		addrT addr;
	} stageOneT;

endpackage

`default_nettype wire

// File: rtl/fetchUnit.sv
`default_nettype none

module fetchUnit
(
	input wire logic clock_i,
	input wire logic rstN_i,
	// incoming words
	input wire logic fetchValid_i,
	output logic fetchReady_o,
	input wire decodePkg::instrT word_i,
	// pc redirect
	input wire logic redirectValid_i,
	input wire decodePkg::addrT redirectAddr_i,
	// towards the queue
	output logic outValid_o,
	input wire logic outReady_i,
	output decodePkg::fetchedT out_o
);

	decodePkg::addrT pc;
	decodePkg::addrT curAddr;
	logic accept;

	// room when the output register is empty or draining
	assign fetchReady_o = !outValid_o || outReady_i;
	assign accept = fetchValid_i && fetchReady_o;

	// a redirect applies to the word taken in the same cycle
	assign curAddr = redirectValid_i ? redirectAddr_i : pc;

	always_ff @(posedge clock_i)
	begin
		if (!rstN_i)
		begin
			pc <= '0;
			outValid_o <= 1'b0;
		end
		else
		begin
			if (accept)
				pc <= curAddr + decodePkg::addrT'(4);
			else if (redirectValid_i)
				pc <= redirectAddr_i;
			if (accept)
				outValid_o <= 1'b1;
			else if (outReady_i)
				outValid_o <= 1'b0;
		end
	end

	// tagged word
	always_ff @(posedge clock_i)
	begin
		if (accept)
		begin
			out_o.instr <= word_i;
			out_o.addr <= curAddr;
		end
	end

endmodule

`default_nettype wire

// File: rtl/instructionQueue.sv
`default_nettype none

`include "decodeCfg.svh"

module instructionQueue
#(
	parameter int DEPTH = `QUEUE_DEPTH
)
(
	input wire logic clock_i,
	input wire logic rstN_i,
	input wire logic inValid_i,
	output logic inReady_o,
	input wire decodePkg::fetchedT in_i,
	output logic outValid_o,
	input wire logic outReady_i,
	output decodePkg::fetchedT out_o
);

	localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

	decodePkg::fetchedT mem [DEPTH];
	logic [PTR_WIDTH-1:0] wrPtr;
	logic [PTR_WIDTH-1:0] rdPtr;
	logic [COUNT_WIDTH-1:0] count;
	logic push;
	logic pop;

	// move the oldest entry into the output register when it is free
	assign pop = (count != '0) && (!outValid_o || outReady_i);
	// a full ring still takes a word while one leaves
	assign inReady_o = (count != COUNT_WIDTH'(DEPTH)) || pop;
	assign push = inValid_i && inReady_o;

	////////////////////////////////////////////////////////////
	// pointers, occupancy, output valid
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock_i)
	begin
		if (!rstN_i)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			outValid_o <= 1'b0;
		end
		else
		begin
			if (push)
				wrPtr <= (wrPtr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			if (pop)
				outValid_o <= 1'b1;
			else if (outReady_i)
				outValid_o <= 1'b0;
		end
	end

	// storage
	always_ff @(posedge clock_i)
	begin
		if (push)
			mem[wrPtr] <= in_i;
		if (pop)
			out_o <= mem[rdPtr];
	end

endmodule

`default_nettype wire

// File: rtl/formatDecoders.sv
`default_nettype none

module formatDecoders
(
	input wire logic clock_i,
	input wire logic rstN_i,
	input wire logic advance_i,
	input wire decodePkg::fetchedT in_i,
	output decodePkg::stageOneT stageOne_o
);

	decodePkg::opcodeT opcode;
	logic [0:8] xo9;
	logic xoCode;
	decodePkg::stageOneT fields;

	assign opcode = in_i.instr[0:5];
	// XO keeps its opcode in 22..30, bit 21 is OE
	assign xo9 = in_i.instr[22:30];
	assign xoCode = ({1'b0, xo9} == decodePkg::XOP_ADD) ||
		({1'b0, xo9} == decodePkg::XOP_SUBF);

	always_comb
	begin
		////////////////////////////////////////////////////////////
		// D format: rt/rs, ra, 16-bit immediate
		////////////////////////////////////////////////////////////
		fields.dMatch = (opcode == decodePkg::OP_ADDI) ||
			(opcode == decodePkg::OP_ADDIS) ||
			(opcode == decodePkg::OP_ORI);
		fields.dReg1 = in_i.instr[6:10];
		fields.dReg2 = in_i.instr[11:15];
		fields.dImm = in_i.instr[16:31];
		// ori is the only unsigned one here
		fields.dSigned = opcode != decodePkg::OP_ORI;
		fields.dShift = opcode == decodePkg::OP_ADDIS;
		fields.dReg2ValOrZero = (opcode == decodePkg::OP_ADDI) ||
			(opcode == decodePkg::OP_ADDIS);

		// DS format, low two bits are the sub opcode
		fields.dsMatch = opcode == decodePkg::OP_LD;
		fields.dsReg1 = in_i.instr[6:10];
		fields.dsReg2 = in_i.instr[11:15];
		fields.dsImm = in_i.instr[16:29];

		// X format
		fields.xMatch = (opcode == decodePkg::OP_X) && !xoCode;
		fields.xReg1 = in_i.instr[6:10];
		fields.xReg2 = in_i.instr[11:15];
		fields.xReg3 = in_i.instr[16:20];
		fields.xXop = in_i.instr[21:30];

		// XO format
		fields.xoMatch = (opcode == decodePkg::OP_X) && xoCode;
		fields.xoReg1 = in_i.instr[6:10];
		fields.xoReg2 = in_i.instr[11:15];
		fields.xoReg3 = in_i.instr[16:20];
		fields.xoXop = xo9;

		// MD format, sh is split with its msb in bit 30
		fields.mdMatch = opcode == decodePkg::OP_RLDICL;
		fields.mdReg1 = in_i.instr[6:10];
		fields.mdReg2 = in_i.instr[11:15];
		fields.mdShift = {in_i.instr[30], in_i.instr[16:20]};

		// bypass
		fields.opcode = opcode;
		fields.addr = in_i.addr;
	end

	always_ff @(posedge clock_i)
	begin
		if (!rstN_i)
		begin
			stageOne_o.dMatch <= 1'b0;
			stageOne_o.dsMatch <= 1'b0;
			stageOne_o.xMatch <= 1'b0;
			stageOne_o.xoMatch <= 1'b0;
			stageOne_o.mdMatch <= 1'b0;
		end
		else if (advance_i)
			stageOne_o <= fields;
	end

endmodule

`default_nettype wire

// File: rtl/decodeMux.sv
`default_nettype none

module decodeMux
(
	input wire logic clock_i,
	input wire logic rstN_i,
	input wire logic advance_i,
	input wire decodePkg::stageOneT stageOne_i,
	output decodePkg::decodedT dec_o
);

	decodePkg::decodedT result;

	always_comb
	begin
		// nothing enabled unless a format matched
		result = '0;
		result.format = decodePkg::INVALID;
		result.opcode = stageOne_i.opcode;
		result.addr = stageOne_i.addr;

		if (stageOne_i.dMatch)
		begin
			result.format = decodePkg::D;
			result.reg1 = stageOne_i.dReg1;
			result.reg2 = stageOne_i.dReg2;
			result.reg1Enable = 1'b1;
			result.reg2Enable = 1'b1;
			result.reg2ValOrZero = stageOne_i.dReg2ValOrZero;
			result.immEnable = 1'b1;
			// addis, value moved up two bytes before extension
			if (stageOne_i.dShift)
				result.imm = {{32{stageOne_i.dImm[0]}}, stageOne_i.dImm, 16'h0000};
			else if (stageOne_i.dSigned)
				result.imm = {{48{stageOne_i.dImm[0]}}, stageOne_i.dImm};
			else
				result.imm = {48'h0, stageOne_i.dImm};
		end
		else if (stageOne_i.dsMatch)
		begin
			result.format = decodePkg::DS;
			result.reg1 = stageOne_i.dsReg1;
			result.reg2 = stageOne_i.dsReg2;
			result.reg1Enable = 1'b1;
			result.reg2Enable = 1'b1;
			result.reg2ValOrZero = 1'b1;
			result.immEnable = 1'b1;
			// word aligned displacement
			result.imm = {{48{stageOne_i.dsImm[0]}}, stageOne_i.dsImm, 2'b00};
		end
		else if (stageOne_i.xMatch)
		begin
			result.format = decodePkg::X;
			result.reg1 = stageOne_i.xReg1;
			result.reg2 = stageOne_i.xReg2;
			result.reg3 = stageOne_i.xReg3;
			result.reg1Enable = 1'b1;
			result.reg2Enable = 1'b1;
			result.reg3Enable = 1'b1;
			result.xOpcode = stageOne_i.xXop;
			result.xOpcodeEnable = 1'b1;
		end
		else if (stageOne_i.xoMatch)
		begin
			result.format = decodePkg::XO;
			result.reg1 = stageOne_i.xoReg1;
			result.reg2 = stageOne_i.xoReg2;
			result.reg3 = stageOne_i.xoReg3;
			result.reg1Enable = 1'b1;
			result.reg2Enable = 1'b1;
			result.reg3Enable = 1'b1;
			result.xOpcode = {1'b0, stageOne_i.xoXop};
			result.xOpcodeEnable = 1'b1;
		end
		else if (stageOne_i.mdMatch)
		begin
			result.format = decodePkg::MD;
			result.reg1 = stageOne_i.mdReg1;
			result.reg2 = stageOne_i.mdReg2;
			result.reg1Enable = 1'b1;
			result.reg2Enable = 1'b1;
			// shift amount takes the place of a third register
			result.reg3IsImmediate = 1'b1;
			result.immEnable = 1'b1;
			result.imm = {58'h0, stageOne_i.mdShift};
		end
	end

	always_ff @(posedge clock_i)
	begin
		if (!rstN_i)
			dec_o <= '0;
		else if (advance_i)
			dec_o <= result;
	end

endmodule

`default_nettype wire

// File: rtl/decodeUnit.sv
`default_nettype none

module decodeUnit
(
	input wire logic clock_i,
	input wire logic rstN_i,
	input wire logic inValid_i,
	output logic inReady_o,
	input wire decodePkg::fetchedT in_i,
	output logic decValid_o,
	input wire logic decReady_i,
	output decodePkg::decodedT dec_o
);

	logic stageOneValid;
	logic stageTwoValid;
	logic advanceOne;
	logic advanceTwo;
	decodePkg::stageOneT stageOne;

	// stage two loads when empty or handing its item off
	assign advanceTwo = stageOneValid && (!stageTwoValid || decReady_i);
	// stage one refills when empty or moving on, so bubbles close up
	assign inReady_o = !stageOneValid || advanceTwo;
	assign advanceOne = inValid_i && inReady_o;
	assign decValid_o = stageTwoValid;

	always_ff @(posedge clock_i)
	begin
		if (!rstN_i)
		begin
			stageOneValid <= 1'b0;
			stageTwoValid <= 1'b0;
		end
		else
		begin
			if (inReady_o)
				stageOneValid <= inValid_i;
			if (!stageTwoValid || decReady_i)
				stageTwoValid <= stageOneValid;
		end
	end

	formatDecoders i_formatDecoders
	(
		.clock_i(clock_i),
		.rstN_i(rstN_i),
		.advance_i(advanceOne),
		.in_i(in_i),
		.stageOne_o(stageOne)
	);

	decodeMux i_decodeMux
	(
		.clock_i(clock_i),
		.rstN_i(rstN_i),
		.advance_i(advanceTwo),
		.stageOne_i(stageOne),
		.dec_o(dec_o)
	);

endmodule

`default_nettype wire

// File: rtl/decodeTop.sv
`default_nettype none

`include "decodeCfg.svh"

module decodeTop
(
	input wire logic clock_i,
	input wire logic rstN_i,
	input wire logic fetchValid_i,
	output logic fetchReady_o,
	input wire decodePkg::instrT word_i,
	input wire logic redirectValid_i,
	input wire decodePkg::addrT redirectAddr_i,
	output logic decValid_o,
	input wire logic decReady_i,
	output decodePkg::decodedT dec_o
);

	// fetch to queue
	logic fetchedValid;
	logic fetchedReady;
	decodePkg::fetchedT fetched;

	// queue to decode
	logic queuedValid;
	logic queuedReady;
	decodePkg::fetchedT queued;

	fetchUnit i_fetch
	(
		.clock_i(clock_i),
		.rstN_i(rstN_i),
		.fetchValid_i(fetchValid_i),
		.fetchReady_o(fetchReady_o),
		.word_i(word_i),
		.redirectValid_i(redirectValid_i),
		.redirectAddr_i(redirectAddr_i),
		.outValid_o(fetchedValid),
		.outReady_i(fetchedReady),
		.out_o(fetched)
	);

	instructionQueue #(.DEPTH(`QUEUE_DEPTH)) i_queue
	(
		.clock_i(clock_i),
		.rstN_i(rstN_i),
		.inValid_i(fetchedValid),
		.inReady_o(fetchedReady),
		.in_i(fetched),
		.outValid_o(queuedValid),
		.outReady_i(queuedReady),
		.out_o(queued)
	);

	decodeUnit i_decode
	(
		.clock_i(clock_i),
		.rstN_i(rstN_i),
		.inValid_i(queuedValid),
		.inReady_o(queuedReady),
		.in_i(queued),
		.decValid_o(decValid_o),
		.decReady_i(decReady_i),
		.dec_o(dec_o)
	);

endmodule

`default_nettype wire

// File: verification/decodeChecker.sv
`default_nettype none

module decodeChecker
(
	input wire logic clock_i,
	input wire logic rstN_i,
	input wire logic fetchValid_i,
	input wire logic fetchReady_i,
	input wire decodePkg::instrT word_i,
	input wire logic redirectValid_i,
	input wire decodePkg::addrT redirectAddr_i,
	input wire logic [95:0] testName_i,
	input wire logic decValid_i,
	input wire logic decReady_i,
	input wire decodePkg::decodedT dec_i,
	output int errorCount_o,
	output int receivedCount_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// edges from an accepted word to decValid rising
	localparam int LATENCY = 4;

	typedef struct packed
	{
		logic [95:0] name;
		decodePkg::decodedT value;
		logic [31:0] acceptCycle;
		logic [31:0] stallMark;
		logic timed;
	} expectT;

	expectT pending [$];
	decodePkg::addrT pc;
	int cycle;
	int stallCycles;

	initial
	begin
		errorCount_o = 0;
		receivedCount_o = 0;
		cycle = 0;
		stallCycles = 0;
		pc = '0;
	end

	////////////////////////////////////////////////////////////
	// reference model of the decode rules
	////////////////////////////////////////////////////////////
	function automatic decodePkg::decodedT expectedFor(decodePkg::instrT w, decodePkg::addrT a);
		decodePkg::decodedT e;
		decodePkg::opcodeT op;
		logic [0:8] xo;
		logic signed [63:0] wide;
		e = '0;
		op = w[0:5];
		xo = w[22:30];
		e.format = decodePkg::INVALID;
		e.opcode = op;
		e.addr = a;
		case (op)
			decodePkg::OP_ADDI, decodePkg::OP_ADDIS, decodePkg::OP_ORI:
			begin
				e.format = decodePkg::D;
				e.reg1 = w[6:10];
				e.reg2 = w[11:15];
				e.reg1Enable = 1'b1;
				e.reg2Enable = 1'b1;
				e.immEnable = 1'b1;
				e.reg2ValOrZero = op != decodePkg::OP_ORI;
				if (op == decodePkg::OP_ADDI)
					wide = $signed(w[16:31]);
				else if (op == decodePkg::OP_ADDIS)
					wide = $signed({w[16:31], 16'h0000});
				else
					wide = {48'h0, w[16:31]};
				e.imm = wide;
			end
			decodePkg::OP_LD:
			begin
				e.format = decodePkg::DS;
				e.reg1 = w[6:10];
				e.reg2 = w[11:15];
				e.reg1Enable = 1'b1;
				e.reg2Enable = 1'b1;
				e.immEnable = 1'b1;
				e.reg2ValOrZero = 1'b1;
				wide = $signed({w[16:29], 2'b00});
				e.imm = wide;
			end
			decodePkg::OP_RLDICL:
			begin
				e.format = decodePkg::MD;
				e.reg1 = w[6:10];
				e.reg2 = w[11:15];
				e.reg1Enable = 1'b1;
				e.reg2Enable = 1'b1;
				e.immEnable = 1'b1;
				e.reg3IsImmediate = 1'b1;
				// bit 30 is the high bit of the shift
				e.imm = {58'h0, w[30], w[16:20]};
			end
			decodePkg::OP_X:
			begin
				e.reg1 = w[6:10];
				e.reg2 = w[11:15];
				e.reg3 = w[16:20];
				e.reg1Enable = 1'b1;
				e.reg2Enable = 1'b1;
				e.reg3Enable = 1'b1;
				e.xOpcodeEnable = 1'b1;
				if (xo == 9'd266 || xo == 9'd40)
				begin
					e.format = decodePkg::XO;
					e.xOpcode = {1'b0, xo};
				end
				else
				begin
					e.format = decodePkg::X;
					e.xOpcode = w[21:30];
				end
			end
			default:
				e.format = decodePkg::INVALID;
		endcase
		return e;
	endfunction

	task automatic checkOutput();
		expectT head;
		int appearEdge;
		receivedCount_o = receivedCount_o + 1;
		if (pending.size() == 0)
		begin
			$display("decoded output at address %h arrived with no word pending", dec_i.addr);
			errorCount_o = errorCount_o + 1;
			return;
		end
		head = pending.pop_front();
		if (dec_i !== head.value)
		begin
			$display("FAILED %0s expected %h actual %h", head.name, head.value, dec_i);
			errorCount_o = errorCount_o + 1;
		end
		// valid rose after the previous edge
		appearEdge = cycle - 1;
		if (head.timed && head.stallMark == stallCycles &&
			appearEdge - int'(head.acceptCycle) != LATENCY)
		begin
			$display("FAILED %0s latency expected %0d actual %0d", head.name, LATENCY,
				appearEdge - int'(head.acceptCycle));
			errorCount_o = errorCount_o + 1;
		end
	endtask

	task automatic recordInput();
		expectT entry;
		decodePkg::addrT addr;
		addr = redirectValid_i ? redirectAddr_i : pc;
		pc = addr + 64'd4;
		entry.name = testName_i;
		entry.value = expectedFor(word_i, addr);
		entry.acceptCycle = cycle;
		entry.stallMark = stallCycles;
		// only an empty pipeline gives a clean latency figure
		entry.timed = pending.size() == 0;
		pending.push_back(entry);
	endtask

	////////////////////////////////////////////////////////////
	// port monitor
	////////////////////////////////////////////////////////////
	always @(posedge clock_i)
	begin
		if (!rstN_i)
		begin
			pc = '0;
			pending.delete();
		end
		else
		begin
			cycle = cycle + 1;
			if (!decReady_i)
				stallCycles = stallCycles + 1;
			if (decValid_i && decReady_i)
				checkOutput();
			if (fetchValid_i && fetchReady_i)
				recordInput();
			else if (redirectValid_i)
				pc = redirectAddr_i;
		end
	end

endmodule

`default_nettype wire

// File: verification/decodeTb.sv
`default_nettype none

module decodeTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_ENTRIES = 20;
	localparam int CYCLE_LIMIT = NUM_ENTRIES * 8 + 50;

	typedef struct packed
	{
		logic [95:0] name;
		decodePkg::instrT word;
		logic redirect;
		decodePkg::addrT target;
		logic isolated;
	} stimT;

	logic clock_i;
	logic rstN_i;
	logic fetchValid_i;
	logic fetchReady_o;
	decodePkg::instrT word_i;
	logic redirectValid_i;
	decodePkg::addrT redirectAddr_i;
	logic decValid_o;
	logic decReady_i;
	decodePkg::decodedT dec_o;
	logic [95:0] testName;
	int errorCount;
	int receivedCount;
	int cycleCount;
	logic randomStall;
	stimT stimTable [NUM_ENTRIES];

	initial clock_i = 1'b0;
	always #10 clock_i = ~clock_i;

	decodeTop i_dut
	(
		.clock_i(clock_i),
		.rstN_i(rstN_i),
		.fetchValid_i(fetchValid_i),
		.fetchReady_o(fetchReady_o),
		.word_i(word_i),
		.redirectValid_i(redirectValid_i),
		.redirectAddr_i(redirectAddr_i),
		.decValid_o(decValid_o),
		.decReady_i(decReady_i),
		.dec_o(dec_o)
	);

	decodeChecker i_checker
	(
		.clock_i(clock_i),
		.rstN_i(rstN_i),
		.fetchValid_i(fetchValid_i),
		.fetchReady_i(fetchReady_o),
		.word_i(word_i),
		.redirectValid_i(redirectValid_i),
		.redirectAddr_i(redirectAddr_i),
		.testName_i(testName),
		.decValid_i(decValid_o),
		.decReady_i(decReady_i),
		.dec_i(dec_o),
		.errorCount_o(errorCount),
		.receivedCount_o(receivedCount)
	);

	task automatic setEntry(int idx, logic [95:0] name, decodePkg::instrT word,
		logic redirect, decodePkg::addrT target, logic isolated);
		stimTable[idx] = {name, word, redirect, target, isolated};
	endtask

	////////////////////////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////////////////////////
	task automatic loadTable();
		// isolated words, back-pressure off, latency measured
		setEntry(0, "addiNeg", {6'd14, 5'd3, 5'd1, 16'hFFF8}, 0, 0, 1);
		setEntry(1, "addisNeg", {6'd15, 5'd4, 5'd2, 16'h8001}, 0, 0, 1);
		setEntry(2, "oriHigh", {6'd24, 5'd5, 5'd6, 16'hFFFF}, 0, 0, 1);
		setEntry(3, "ldNeg", {6'd58, 5'd7, 5'd1, 14'h3FFE, 2'b00}, 0, 0, 1);
		setEntry(4, "rldicl", {6'd30, 5'd8, 5'd9, 5'd3, 6'd0, 3'd0, 1'b1, 1'b0}, 0, 0, 1);
		setEntry(5, "xAnd", {6'd31, 5'd10, 5'd11, 5'd12, 10'd28, 1'b0}, 0, 0, 1);
		setEntry(6, "xoAdd", {6'd31, 5'd13, 5'd14, 5'd15, 1'b0, 9'd266, 1'b0}, 0, 0, 1);
		setEntry(7, "xoSubfo", {6'd31, 5'd16, 5'd17, 5'd18, 1'b1, 9'd40, 1'b0}, 0, 0, 1);
		setEntry(8, "invalid", {6'd1, 26'h1ABCDEF}, 0, 0, 1);
		setEntry(9, "redirAddi", {6'd14, 5'd1, 5'd0, 16'h0010}, 1, 64'h10000, 1);
		// back to back under random back-pressure
		setEntry(10, "addiPos", {6'd14, 5'd2, 5'd3, 16'h7FFF}, 0, 0, 0);
		setEntry(11, "addisPos", {6'd15, 5'd3, 5'd0, 16'h1234}, 0, 0, 0);
		setEntry(12, "ldPos", {6'd58, 5'd4, 5'd5, 14'h0010, 2'b00}, 0, 0, 0);
		setEntry(13, "xOr", {6'd31, 5'd6, 5'd7, 5'd8, 10'd444, 1'b0}, 0, 0, 0);
		setEntry(14, "redirLd", {6'd58, 5'd9, 5'd1, 14'h2000, 2'b00}, 1,
			64'hFFFF_FFFF_0000_1000, 0);
		setEntry(15, "xoAddo", {6'd31, 5'd10, 5'd11, 5'd12, 1'b1, 9'd266, 1'b1}, 0, 0, 0);
		setEntry(16, "rldiclLo", {6'd30, 5'd13, 5'd14, 5'd31, 6'd5, 3'd0, 1'b0, 1'b1}, 0, 0, 0);
		setEntry(17, "oriZero", {6'd24, 5'd0, 5'd0, 16'h0000}, 0, 0, 0);
		setEntry(18, "badOp", {6'd63, 26'h0}, 0, 0, 0);
		setEntry(19, "xSlw", {6'd31, 5'd15, 5'd16, 5'd17, 10'd24, 1'b0}, 0, 0, 0);
	endtask

	// one falling edge, new decReady_i value
	task automatic stepCycle();
		@(negedge clock_i);
		decReady_i = randomStall ? ($urandom % 3 != 0) : 1'b1;
	endtask

	task automatic waitForDrain(int count);
		while (receivedCount != count)
			stepCycle();
	endtask

	// hold the word until the fetch unit takes it
	task automatic sendWord(stimT entry);
		logic ready;
		fetchValid_i = 1'b1;
		word_i = entry.word;
		testName = entry.name;
		redirectValid_i = entry.redirect;
		redirectAddr_i = entry.redirect ? entry.target : '0;
		ready = 1'b0;
		while (!ready)
		begin
			#1;
			ready = fetchReady_o;
			if (!ready)
				stepCycle();
		end
		stepCycle();
		fetchValid_i = 1'b0;
		redirectValid_i = 1'b0;
		redirectAddr_i = '0;
	endtask

	initial
	begin
		void'($urandom(35));
		rstN_i = 1'b0;
		fetchValid_i = 1'b0;
		word_i = '0;
		redirectValid_i = 1'b0;
		redirectAddr_i = '0;
		decReady_i = 1'b1;
		testName = '0;
		randomStall = 1'b0;
		loadTable();
		repeat (2) @(posedge clock_i);
		@(negedge clock_i);
		rstN_i = 1'b1;
		for (int i = 0; i < NUM_ENTRIES; i++)
		begin
			randomStall = !stimTable[i].isolated;
			if (stimTable[i].isolated)
				waitForDrain(i);
			sendWord(stimTable[i]);
		end
		randomStall = 1'b0;
		waitForDrain(NUM_ENTRIES);
		// a few idle cycles to catch stray outputs
		repeat (4) stepCycle();
		$display("%0d of %0d words decoded, %0d errors", receivedCount, NUM_ENTRIES, errorCount);
		if (errorCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// watchdog
	////////////////////////////////////////////////////////////
	initial cycleCount = 0;

	always @(posedge clock_i)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT)
		begin
			$display("timeout after %0d cycles, %0d decoded words never came out",
				cycleCount, NUM_ENTRIES - receivedCount);
			$display("%0d of %0d words decoded, %0d errors", receivedCount, NUM_ENTRIES,
				errorCount);
			$display("ERRORS FOUND");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+rtl
rtl/decodePkg.sv
rtl/fetchUnit.sv
rtl/instructionQueue.sv
rtl/formatDecoders.sv
rtl/decodeMux.sv
rtl/decodeUnit.sv
rtl/decodeTop.sv
verification/decodeChecker.sv
verification/decodeTb.sv

// File: Bender.yml
package:
  name: decode_front

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/decodePkg.sv
      - rtl/fetchUnit.sv
      - rtl/instructionQueue.sv
      - rtl/formatDecoders.sv
      - rtl/decodeMux.sv
      - rtl/decodeUnit.sv
      - rtl/decodeTop.sv
  - target: test
    files:
      - verification/decodeChecker.sv
      - verification/decodeTb.sv
